// ==== include/lc3b_defines.svh ====
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// datapath sizes
`define LC3B_WORD_W     16
`define LC3B_REG_W      3
`define LC3B_NUM_REGS   8
`define LC3B_OPCODE_W   4

// first fetch after reset
`define LC3B_RESET_PC   16'h0000

// opcodes kept from the lc-3b encoding
`define LC3B_OP_BR      4'b0000
`define LC3B_OP_ADD     4'b0001
`define LC3B_OP_AND     4'b0101
`define LC3B_OP_LDR     4'b0110
`define LC3B_OP_STR     4'b0111
`define LC3B_OP_NOT     4'b1001

// forwarding mux selects into execute
`define LC3B_FWD_NONE   2'd0
`define LC3B_FWD_MEM    2'd1
`define LC3B_FWD_WB     2'd2

`endif

// ==== verilog/lc3b_pkg.sv ====
`include "lc3b_defines.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] word_t;
    typedef logic [`LC3B_REG_W-1:0] reg_idx_t;
    typedef logic [`LC3B_OPCODE_W-1:0] opcode_t;

    // add / and / not; low 3 bits of src2 are sr2 when imm_flag is clear
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t dr;
        reg_idx_t sr1;
        logic     imm_flag;
        logic [4:0] src2;
    } op_fmt_t;

    // ldr / str
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t dsr;
        reg_idx_t base;
        logic [5:0] offset6;
    } mem_fmt_t;

    typedef struct packed {
        opcode_t  opcode;
        logic     n;
        logic     z;
        logic     p;
        logic [8:0] offset9;
    } br_fmt_t;

    typedef union packed {
        op_fmt_t  op;
        mem_fmt_t mem;
        br_fmt_t  br;
    } instr_u;

    typedef enum logic [1:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_AND,
        ALU_NOT
    } alu_op_e;

    typedef enum logic [1:0] {
        OPB_REG,
        OPB_IMM,
        OPB_OFF
    } opb_sel_e;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } dmem_req_t;

    typedef struct packed {
        word_t  pc_plus2;
        instr_u instr;
        logic   valid;
    } if_id_t;

    typedef struct packed {
        word_t    pc_plus2;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        word_t    offset;
        reg_idx_t sr1;
        reg_idx_t sr2;
        reg_idx_t dr;
        alu_op_e  alu_op;
        opb_sel_e b_sel;
        logic     a_pc;
        logic     has_store_data;
        logic     load;
        logic     store;
        logic     reg_we;
        logic     cc_we;
        logic     branch;
        logic [2:0] nzp;
        logic     valid;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dr;
        logic     load;
        logic     store;
        logic     reg_we;
        logic     cc_we;
        logic     branch;
        logic     valid;
        logic [2:0] nzp;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t dr;
        logic     load;
        logic     reg_we;
        logic     cc_we;
        logic     branch;
        logic     valid;
        logic [2:0] nzp;
    } mem_wb_t;

endpackage

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module fetch_stage
(
    input  logic              clk,
    input  logic              reset,
    input  logic              freeze,
    input  logic              load_stall,
    input  logic              flush,
    input  lc3b_pkg::word_t   redirect_pc,
    input  logic              imem_resp,
    input  lc3b_pkg::word_t   imem_rdata,
    output lc3b_pkg::word_t   imem_addr,
    output logic              imem_read,
    output lc3b_pkg::if_id_t  if_id
);

    lc3b_pkg::word_t pc;
    lc3b_pkg::word_t pc_plus2;
    lc3b_pkg::word_t fetched;
    lc3b_pkg::word_t hold_word;
    logic            hold_valid;
    logic            advance;

    // a word returned while the pipeline is held waits here, no re-read
    assign imem_addr = pc;
    assign imem_read = !hold_valid;
    assign pc_plus2  = pc + `LC3B_WORD_W'(2);
    assign advance   = !freeze && !load_stall;
    assign fetched   = hold_valid ? hold_word : imem_rdata;

    always_ff @(posedge clk)
    begin
        if (imem_read && imem_resp)
            hold_word <= imem_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc         <= `LC3B_RESET_PC;
            hold_valid <= 1'b0;
            if_id      <= '0;
        end
        else if (!freeze && flush)
        begin
            // wrong-path word is dropped, restart at the branch target
            pc          <= redirect_pc;
            hold_valid  <= 1'b0;
            if_id.valid <= 1'b0;
        end
        else if (advance)
        begin
            pc             <= pc_plus2;
            hold_valid     <= 1'b0;
            if_id.pc_plus2 <= pc_plus2;
            if_id.instr    <= fetched;
            if_id.valid    <= 1'b1;
        end
        else if (imem_resp)
            hold_valid <= 1'b1;
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module decode_stage
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   freeze,
    input  logic                   load_stall,
    input  logic                   flush,
    input  lc3b_pkg::if_id_t       if_id,
    input  logic                   rf_we,
    input  logic [`LC3B_REG_W-1:0] rf_waddr,
    input  lc3b_pkg::word_t        rf_wdata,
    output lc3b_pkg::id_ex_t       id_ex
);

    lc3b_pkg::word_t    regs [`LC3B_NUM_REGS];
    lc3b_pkg::instr_u   ir;
    lc3b_pkg::id_ex_t   dec;
    lc3b_pkg::reg_idx_t rd_a_idx;
    lc3b_pkg::reg_idx_t rd_b_idx;
    lc3b_pkg::word_t    rd_a_val;
    lc3b_pkg::word_t    rd_b_val;

    assign ir = if_id.instr;

    always_comb
    begin
        dec          = '0;
        dec.pc_plus2 = if_id.pc_plus2;
        dec.imm      = {{(`LC3B_WORD_W-5){ir.op.src2[4]}}, ir.op.src2};
        dec.sr1      = ir.op.sr1;
        dec.sr2      = ir.op.src2[2:0];
        dec.dr       = ir.op.dr;
        dec.nzp      = {ir.br.n, ir.br.z, ir.br.p};
        dec.valid    = if_id.valid;
        if (if_id.valid)
        begin
            case (ir.op.opcode)
                `LC3B_OP_ADD, `LC3B_OP_AND:
                begin
                    dec.alu_op = (ir.op.opcode == `LC3B_OP_ADD) ?
                                 lc3b_pkg::ALU_ADD : lc3b_pkg::ALU_AND;
                    dec.b_sel  = ir.op.imm_flag ? lc3b_pkg::OPB_IMM : lc3b_pkg::OPB_REG;
                    dec.reg_we = 1'b1;
                    dec.cc_we  = 1'b1;
                end
                `LC3B_OP_NOT:
                begin
                    dec.alu_op = lc3b_pkg::ALU_NOT;
                    dec.reg_we = 1'b1;
                    dec.cc_we  = 1'b1;
                end
                `LC3B_OP_LDR:
                begin
                    // word-scaled offset, base + (offset6 << 1)
                    dec.alu_op = lc3b_pkg::ALU_ADD;
                    dec.b_sel  = lc3b_pkg::OPB_OFF;
                    dec.offset = {{(`LC3B_WORD_W-7){ir.mem.offset6[5]}}, ir.mem.offset6, 1'b0};
                    dec.sr1    = ir.mem.base;
                    dec.dr     = ir.mem.dsr;
                    dec.load   = 1'b1;
                    dec.reg_we = 1'b1;
                    dec.cc_we  = 1'b1;
                end
                `LC3B_OP_STR:
                begin
                    // stored register rides on the second read port
                    dec.alu_op         = lc3b_pkg::ALU_ADD;
                    dec.b_sel          = lc3b_pkg::OPB_OFF;
                    dec.offset = {{(`LC3B_WORD_W-7){ir.mem.offset6[5]}}, ir.mem.offset6, 1'b0};
                    dec.sr1            = ir.mem.base;
                    dec.sr2            = ir.mem.dsr;
                    dec.store          = 1'b1;
                    dec.has_store_data = 1'b1;
                end
                `LC3B_OP_BR:
                begin
                    dec.alu_op = lc3b_pkg::ALU_ADD;
                    dec.a_pc   = 1'b1;
                    dec.b_sel  = lc3b_pkg::OPB_OFF;
                    dec.offset = {{(`LC3B_WORD_W-10){ir.br.offset9[8]}}, ir.br.offset9, 1'b0};
                    dec.branch = 1'b1;
                end
                default:
                begin
                    // unsupported opcodes travel on as a bubble
                    dec.valid = 1'b0;
                end
            endcase
        end
    end

    // while stalled the held instruction re-reads its own sources
    assign rd_a_idx = load_stall ? id_ex.sr1 : dec.sr1;
    assign rd_b_idx = load_stall ? id_ex.sr2 : dec.sr2;

    // write-through so a same-cycle writeback is seen
    assign rd_a_val = (rf_we && rf_waddr == rd_a_idx) ? rf_wdata : regs[rd_a_idx];
    assign rd_b_val = (rf_we && rf_waddr == rd_b_idx) ? rf_wdata : regs[rd_b_idx];

    always_ff @(posedge clk)
    begin
        if (rf_we)
            regs[rf_waddr] <= rf_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            id_ex <= '0;
        else if (!freeze)
        begin
            if (flush)
                id_ex <= '0;
            else
            begin
                if (!load_stall)
                    id_ex <= dec;
                // refresh operands, picks up the result leaving writeback
                id_ex.rs1_val <= rd_a_val;
                id_ex.rs2_val <= rd_b_val;
            end
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module execute_stage
(
    input  logic              clk,
    input  logic              reset,
    input  logic              freeze,
    input  logic              flush,
    input  lc3b_pkg::id_ex_t  id_ex,
    input  logic [1:0]        fwd_a_sel,
    input  logic [1:0]        fwd_b_sel,
    input  lc3b_pkg::word_t   mem_fwd_data,
    input  lc3b_pkg::word_t   wb_fwd_data,
    output lc3b_pkg::ex_mem_t ex_mem
);

    lc3b_pkg::word_t   src_a;
    lc3b_pkg::word_t   src_b;
    lc3b_pkg::word_t   op_a;
    lc3b_pkg::word_t   op_b;
    lc3b_pkg::word_t   alu_out;
    lc3b_pkg::ex_mem_t next;

    function automatic lc3b_pkg::word_t fwd_pick(input logic [1:0] sel,
                                                 input lc3b_pkg::word_t reg_val,
                                                 input lc3b_pkg::word_t mem_val,
                                                 input lc3b_pkg::word_t wb_val);
        case (sel)
            `LC3B_FWD_MEM: return mem_val;
            `LC3B_FWD_WB:  return wb_val;
            default:       return reg_val;
        endcase
    endfunction

    assign src_a = fwd_pick(fwd_a_sel, id_ex.rs1_val, mem_fwd_data, wb_fwd_data);
    assign src_b = fwd_pick(fwd_b_sel, id_ex.rs2_val, mem_fwd_data, wb_fwd_data);

    // branch target is pc+2 plus the scaled offset
    assign op_a = id_ex.a_pc ? id_ex.pc_plus2 : src_a;

    always_comb
    begin
        case (id_ex.b_sel)
            lc3b_pkg::OPB_IMM: op_b = id_ex.imm;
            lc3b_pkg::OPB_OFF: op_b = id_ex.offset;
            default:           op_b = src_b;
        endcase
    end

    always_comb
    begin
        case (id_ex.alu_op)
            lc3b_pkg::ALU_ADD: alu_out = op_a + op_b;
            lc3b_pkg::ALU_AND: alu_out = op_a & op_b;
            lc3b_pkg::ALU_NOT: alu_out = ~op_a;
            default:           alu_out = op_b;
        endcase
    end

    always_comb
    begin
        next.alu_result = alu_out;
        next.store_data = id_ex.has_store_data ? src_b : '0;
        next.dr         = id_ex.dr;
        next.load       = id_ex.load;
        next.store      = id_ex.store;
        next.reg_we     = id_ex.reg_we;
        next.cc_we      = id_ex.cc_we;
        next.branch     = id_ex.branch;
        next.valid      = id_ex.valid;
        next.nzp        = id_ex.nzp;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ex_mem <= '0;
        else if (!freeze)
            ex_mem <= flush ? '0 : next;
    end

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module hazard_unit
(
    input  logic                   ex_valid,
    input  logic [`LC3B_REG_W-1:0] ex_sr1,
    input  logic [`LC3B_REG_W-1:0] ex_sr2,
    input  logic [`LC3B_REG_W-1:0] mem_dr,
    input  logic                   mem_reg_we,
    input  logic                   mem_load,
    input  logic [`LC3B_REG_W-1:0] wb_dr,
    input  logic                   wb_reg_we,
    input  logic                   imem_read,
    input  logic                   imem_resp,
    input  logic                   dmem_read,
    input  logic                   dmem_write,
    input  logic                   dmem_resp,
    output logic [1:0]             fwd_a_sel,
    output logic [1:0]             fwd_b_sel,
    output logic                   load_stall,
    output logic                   freeze
);

    logic load_use;

    // younger producer in memory wins over writeback
    function automatic logic [1:0] fwd_select(input logic [`LC3B_REG_W-1:0] src);
        if (mem_reg_we && mem_dr == src)
            return `LC3B_FWD_MEM;
        if (wb_reg_we && wb_dr == src)
            return `LC3B_FWD_WB;
        return `LC3B_FWD_NONE;
    endfunction

    always_comb
    begin
        fwd_a_sel = fwd_select(ex_sr1);
        fwd_b_sel = fwd_select(ex_sr2);
    end

    assign freeze = (imem_read && !imem_resp) || ((dmem_read || dmem_write) && !dmem_resp);

    // load data only exists from writeback on, so wait one cycle
    assign load_use   = ex_valid && mem_load && mem_reg_we &&
                        (mem_dr == ex_sr1 || mem_dr == ex_sr2);
    assign load_stall = load_use && !freeze;

endmodule

// ==== verilog/memory_writeback.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module memory_writeback
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   freeze,
    input  lc3b_pkg::ex_mem_t      ex_mem,
    input  logic                   dmem_resp,
    input  lc3b_pkg::word_t        dmem_rdata,
    output lc3b_pkg::dmem_req_t    dmem_req,
    output lc3b_pkg::word_t        mem_fwd_data,
    output logic                   rf_we,
    output logic [`LC3B_REG_W-1:0] rf_waddr,
    output lc3b_pkg::word_t        rf_wdata,
    output logic                   flush,
    output lc3b_pkg::word_t        redirect_pc
);

    lc3b_pkg::mem_wb_t mem_wb;
    lc3b_pkg::mem_wb_t next;
    lc3b_pkg::word_t   load_hold;
    logic              dmem_done;
    logic [2:0]        cc;
    logic [2:0]        cc_next;

    // a response that lands while the pipeline is held is kept, no second access
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.read  = ex_mem.valid && ex_mem.load && !dmem_done && !flush;
    assign dmem_req.write = ex_mem.valid && ex_mem.store && !dmem_done && !flush;

    assign mem_fwd_data = ex_mem.alu_result;

    always_ff @(posedge clk)
    begin
        if (dmem_resp)
            load_hold <= dmem_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            dmem_done <= 1'b0;
        else if (!freeze)
            dmem_done <= 1'b0;
        else if (dmem_resp)
            dmem_done <= 1'b1;
    end

    always_comb
    begin
        next.alu_result = ex_mem.alu_result;
        next.load_data  = dmem_done ? load_hold : dmem_rdata;
        next.dr         = ex_mem.dr;
        next.load       = ex_mem.load;
        next.reg_we     = ex_mem.reg_we;
        next.cc_we      = ex_mem.cc_we;
        next.branch     = ex_mem.branch;
        next.valid      = ex_mem.valid;
        next.nzp        = ex_mem.nzp;
    end

    // the instruction in memory is younger than a taken branch
    always_ff @(posedge clk)
    begin
        if (reset)
            mem_wb <= '0;
        else if (!freeze)
            mem_wb <= flush ? '0 : next;
    end

    assign rf_we    = mem_wb.valid && mem_wb.reg_we;
    assign rf_waddr = mem_wb.dr;
    assign rf_wdata = mem_wb.load ? mem_wb.load_data : mem_wb.alu_result;

    // n / z / p of the value being written
    assign cc_next = rf_wdata[`LC3B_WORD_W-1] ? 3'b100 :
                     (rf_wdata == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge clk)
    begin
        if (reset)
            cc <= 3'b010;
        else if (mem_wb.valid && mem_wb.cc_we)
            cc <= cc_next;
    end

    assign flush       = mem_wb.valid && mem_wb.branch && |(mem_wb.nzp & cc);
    assign redirect_pc = mem_wb.alu_result;

endmodule

// ==== verilog/lc3b_pipeline.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module lc3b_pipeline
(
    input  logic                clk,
    input  logic                reset,
    output lc3b_pkg::word_t     imem_addr,
    output logic                imem_read,
    input  logic                imem_resp,
    input  lc3b_pkg::word_t     imem_rdata,
    output lc3b_pkg::dmem_req_t dmem_req,
    input  logic                dmem_resp,
    input  lc3b_pkg::word_t     dmem_rdata
);

    lc3b_pkg::if_id_t  if_id;
    lc3b_pkg::id_ex_t  id_ex;
    lc3b_pkg::ex_mem_t ex_mem;

    logic                   freeze;
    logic                   load_stall;
    logic                   flush;
    logic                   ex_kill;
    lc3b_pkg::word_t        redirect_pc;
    logic [1:0]             fwd_a_sel;
    logic [1:0]             fwd_b_sel;
    lc3b_pkg::word_t        mem_fwd_data;
    logic                   rf_we;
    logic [`LC3B_REG_W-1:0] rf_waddr;
    lc3b_pkg::word_t        rf_wdata;

    // a load-use stall holds execute and leaves a bubble behind the load
    assign ex_kill = flush || load_stall;

    fetch_stage i_fetch
    (
        .clk         (clk),
        .reset       (reset),
        .freeze      (freeze),
        .load_stall  (load_stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .imem_resp   (imem_resp),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .imem_read   (imem_read),
        .if_id       (if_id)
    );

    decode_stage i_decode
    (
        .clk        (clk),
        .reset      (reset),
        .freeze     (freeze),
        .load_stall (load_stall),
        .flush      (flush),
        .if_id      (if_id),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .id_ex      (id_ex)
    );

    execute_stage i_execute
    (
        .clk          (clk),
        .reset        (reset),
        .freeze       (freeze),
        .flush        (ex_kill),
        .id_ex        (id_ex),
        .fwd_a_sel    (fwd_a_sel),
        .fwd_b_sel    (fwd_b_sel),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_data  (rf_wdata),
        .ex_mem       (ex_mem)
    );

    memory_writeback i_mem_wb
    (
        .clk          (clk),
        .reset        (reset),
        .freeze       (freeze),
        .ex_mem       (ex_mem),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .dmem_req     (dmem_req),
        .mem_fwd_data (mem_fwd_data),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    hazard_unit i_hazard
    (
        .ex_sr1     (id_ex.sr1),
        .ex_sr2     (id_ex.sr2),
        .ex_valid   (id_ex.valid),
        .mem_dr     (ex_mem.dr),
        .mem_reg_we (ex_mem.valid && ex_mem.reg_we),
        .mem_load   (ex_mem.load),
        .wb_dr      (rf_waddr),
        .wb_reg_we  (rf_we),
        .imem_read  (imem_read),
        .imem_resp  (imem_resp),
        .dmem_read  (dmem_req.read),
        .dmem_write (dmem_req.write),
        .dmem_resp  (dmem_resp),
        .fwd_a_sel  (fwd_a_sel),
        .fwd_b_sel  (fwd_b_sel),
        .load_stall (load_stall),
        .freeze     (freeze)
    );

endmodule

// ==== testbench/tb_lc3b_pipeline.sv ====
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module tb_lc3b_pipeline;

    localparam int PROG_LEN   = 20;
    localparam int NUM_STORES = 6;
    localparam int RUNS       = 2;
    localparam int WATCHDOG_CYCLES = RUNS * (PROG_LEN + NUM_STORES) * 40;
    localparam logic [15:0] LOAD_ADDR = 16'h0030;
    localparam logic [15:0] LOAD_WORD = 16'h1234;
    localparam logic [15:0] LOOP_PC   = 16'h0026;

    logic                clk;
    logic                reset;
    lc3b_pkg::word_t     imem_addr;
    logic                imem_read;
    logic                imem_resp;
    lc3b_pkg::word_t     imem_rdata;
    lc3b_pkg::dmem_req_t dmem_req;
    logic                dmem_resp;
    lc3b_pkg::word_t     dmem_rdata;

    logic [15:0]         imem [64];
    logic [15:0]         dmem [64];
    logic [15:0]         exp_addr [NUM_STORES];
    logic [15:0]         exp_data [NUM_STORES];
    logic [15:0]         lfsr_state;
    logic                random_lat;
    int                  store_idx;
    int                  loop_fetches;
    logic                imem_busy;
    logic                dmem_busy;
    int                  imem_wait;
    int                  dmem_wait;
    logic [15:0]         imem_hold;
    lc3b_pkg::dmem_req_t dmem_hold;

    lc3b_pipeline i_dut
    (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_read  (imem_read),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        fail_run($sformatf("error: %s is %h, expected %h", name, got, expected));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // 0 to 3 extra cycles, two lfsr bits
    function automatic int next_latency();
        int lat;
        lat = 0;
        if (random_lat)
        begin
            for (int i = 0; i < 2; i++)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                lat = (lat << 1) | lfsr_state[0];
            end
        end
        return lat;
    endfunction

    task automatic load_program();
        foreach (imem[i])
            imem[i] = 16'h0000;
        // r0 = 0, then a dependent chain of add / and / not
        imem[0]  = 16'h5020;
        imem[1]  = 16'h1225;
        imem[2]  = 16'h1463;
        imem[3]  = 16'h1681;
        imem[4]  = 16'h58E7;
        imem[5]  = 16'h9B3F;
        // str r3 / r5 / r4 to 0x20, 0x22, 0x24
        imem[6]  = 16'h7610;
        imem[7]  = 16'h7A11;
        imem[8]  = 16'h7812;
        // ldr r6 from 0x30, add r7 = r6 - 3 right behind it, str r7 to 0x26
        imem[9]  = 16'h6C18;
        imem[10] = 16'h1FBD;
        imem[11] = 16'h7E13;
        // brp +2 is taken, both stores in its shadow must vanish
        imem[12] = 16'h0202;
        imem[13] = 16'h7014;
        imem[14] = 16'h7015;
        // r1 = 0 sets z, brn +2 falls through to two stores
        imem[15] = 16'h1220;
        imem[16] = 16'h0802;
        imem[17] = 16'h7416;
        imem[18] = 16'h7217;
        // brnzp -1, spin here
        imem[19] = 16'h0FFF;

        exp_addr[0] = 16'h0020;
        exp_data[0] = 16'h000D;
        exp_addr[1] = 16'h0022;
        exp_data[1] = 16'hFFFA;
        exp_addr[2] = 16'h0024;
        exp_data[2] = 16'h0005;
        exp_addr[3] = 16'h0026;
        exp_data[3] = LOAD_WORD - 16'd3;
        exp_addr[4] = 16'h002C;
        exp_data[4] = 16'h0008;
        exp_addr[5] = 16'h002E;
        exp_data[5] = 16'h0000;
    endtask

    task automatic load_data();
        foreach (dmem[i])
            dmem[i] = 16'hC000 | (i << 1);
        dmem[LOAD_ADDR[6:1]] = LOAD_WORD;
    endtask

    // both memory models in one process so the lfsr order is fixed
    always @(posedge clk)
    begin
        if (reset)
        begin
            imem_resp <= 1'b0;
            dmem_resp <= 1'b0;
            imem_busy = 1'b0;
            dmem_busy = 1'b0;
        end
        else
        begin
            if (imem_resp)
            begin
                assert (imem_read && imem_addr == imem_hold)
                    else fail_run("instruction request changed in its response cycle");
                imem_resp <= 1'b0;
            end
            else if (imem_read || imem_busy)
            begin
                if (!imem_busy)
                begin
                    imem_busy = 1'b1;
                    imem_hold = imem_addr;
                    imem_wait = next_latency();
                end
                assert (imem_read) else fail_run("instruction read dropped before its response");
                assert (imem_addr == imem_hold)
                    else value_error("imem_addr", imem_addr, imem_hold);
                if (imem_wait == 0)
                begin
                    imem_busy = 1'b0;
                    imem_resp  <= 1'b1;
                    imem_rdata <= imem[imem_addr[6:1]];
                    if (imem_addr == LOOP_PC)
                        loop_fetches++;
                end
                else
                    imem_wait--;
            end

            if (dmem_resp)
            begin
                assert (dmem_req == dmem_hold)
                    else fail_run("data request changed in its response cycle");
                dmem_resp <= 1'b0;
            end
            else if (dmem_req.read || dmem_req.write || dmem_busy)
            begin
                if (!dmem_busy)
                begin
                    dmem_busy = 1'b1;
                    dmem_hold = dmem_req;
                    dmem_wait = next_latency();
                end
                assert (dmem_req.read || dmem_req.write)
                    else fail_run("data request dropped before its response");
                assert (dmem_req.addr == dmem_hold.addr)
                    else value_error("dmem_req.addr", dmem_req.addr, dmem_hold.addr);
                assert (dmem_req.wdata == dmem_hold.wdata)
                    else value_error("dmem_req.wdata", dmem_req.wdata, dmem_hold.wdata);
                if (dmem_wait == 0)
                begin
                    dmem_busy = 1'b0;
                    dmem_resp <= 1'b1;
                    if (dmem_req.write)
                    begin
                        assert (store_idx < NUM_STORES)
                            else fail_run("store seen after the last expected store");
                        assert (dmem_req.addr == exp_addr[store_idx])
                            else value_error("dmem_req.addr", dmem_req.addr, exp_addr[store_idx]);
                        assert (dmem_req.wdata == exp_data[store_idx])
                            else value_error("dmem_req.wdata", dmem_req.wdata,
                                             exp_data[store_idx]);
                        dmem[dmem_req.addr[6:1]] = dmem_req.wdata;
                        store_idx++;
                    end
                    else
                    begin
                        assert (dmem_req.addr == LOAD_ADDR)
                            else value_error("dmem_req.addr", dmem_req.addr, LOAD_ADDR);
                        dmem_rdata <= dmem[dmem_req.addr[6:1]];
                    end
                end
                else
                    dmem_wait--;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("timeout: the program did not reach its final loop in time");
    end

    initial
    begin
        reset        = 1'b1;
        imem_resp    = 1'b0;
        imem_rdata   = '0;
        dmem_resp    = 1'b0;
        dmem_rdata   = '0;
        random_lat   = 1'b0;
        lfsr_state   = 16'd64;
        store_idx    = 0;
        loop_fetches = 0;
        load_program();

        // first pass with no extra latency, second with random latency
        for (int run = 0; run < RUNS; run++)
        begin
            @(posedge clk);
            reset <= 1'b1;
            repeat (4) @(posedge clk);
            random_lat   = (run == 1);
            store_idx    = 0;
            loop_fetches = 0;
            load_data();
            reset <= 1'b0;

            @(negedge clk);
            assert (imem_read === 1'b1) else value_error("imem_read", imem_read, 1'b1);
            assert (imem_addr === `LC3B_RESET_PC)
                else value_error("imem_addr", imem_addr, `LC3B_RESET_PC);
            assert (dmem_req.read === 1'b0 && dmem_req.write === 1'b0)
                else fail_run("data memory request active right after reset");

            wait (store_idx == NUM_STORES && loop_fetches >= 3);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
verilog/lc3b_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/hazard_unit.sv
verilog/memory_writeback.sv
verilog/lc3b_pipeline.sv
testbench/tb_lc3b_pipeline.sv
